//--- source/bus_defs_pkg.sv
`default_nettype none

package bus_defs_pkg;

   // bus widths
   localparam int word_width = 32;
   localparam int addr_width = 32;

   typedef logic [word_width-1:0] word_t;
   typedef logic [addr_width-1:0] addr_t;

   // data memory, 4k words
   localparam int mem_addr_size = 12;

   typedef logic [mem_addr_size-1:0] mem_idx_t;

   // one bit per 4k region of the low 64k
   typedef logic [15:0] cs_t;

   // value of addr[15:12] for each peripheral
   // regions 0 to 3 all map onto the memory
   localparam logic [3:0] region_timer    = 4'd12;
   localparam logic [3:0] region_portj    = 4'd13;
   localparam logic [3:0] region_porti    = 4'd14;
   localparam logic [3:0] region_portabcd = 4'd15;

endpackage

`default_nettype wire

//--- source/periph_defs_pkg.sv
`default_nettype none

package periph_defs_pkg;

   // output bank
   localparam int port_count = 4;

   typedef logic [$clog2(port_count)-1:0] port_sel_t;

   // timer register map, word offsets
   typedef logic [1:0] tmr_reg_t;

   localparam tmr_reg_t tmr_reg_ctrl = 2'd0;
   localparam tmr_reg_t tmr_reg_arr  = 2'd1;
   localparam tmr_reg_t tmr_reg_ctr  = 2'd2;
   localparam tmr_reg_t tmr_reg_stat = 2'd3;

   // control register bits
   localparam int ctrl_en_bit     = 0;
   localparam int ctrl_irq_en_bit = 1;

   // flops between an async input and its first use
   localparam int sync_stages = 2;

endpackage

`default_nettype wire

//--- source/addr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module addr_decode (
   input  wire bus_defs_pkg::addr_t bus_addr,
   input  wire bus_defs_pkg::word_t mem_rdata,
   input  wire bus_defs_pkg::word_t timer_rdata,
   input  wire bus_defs_pkg::word_t porti_rdata,
   input  wire bus_defs_pkg::word_t portj_rdata,
   input  wire bus_defs_pkg::word_t outs_rdata,
   output logic                     cs_mem,
   output logic                     cs_timer,
   output logic                     cs_porti,
   output logic                     cs_portj,
   output logic                     cs_outs,
   output bus_defs_pkg::word_t      bus_rdata
);

   import bus_defs_pkg::*;

   logic low_64k;
   cs_t  region_cs;

   assign low_64k = (bus_addr[31:16] == '0);

   // one-hot on addr[15:12], empty above 64k
   always_comb begin
      region_cs = '0;
      region_cs[bus_addr[15:12]] = low_64k;
   end

   assign cs_mem   = |region_cs[3:0];
   assign cs_timer = region_cs[region_timer];
   assign cs_portj = region_cs[region_portj];
   assign cs_porti = region_cs[region_porti];
   assign cs_outs  = region_cs[region_portabcd];

   // memory answers anything no peripheral claims
   always_comb begin
      if (cs_timer) begin
         bus_rdata = timer_rdata;
      end else if (cs_portj) begin
         bus_rdata = portj_rdata;
      end else if (cs_porti) begin
         bus_rdata = porti_rdata;
      end else if (cs_outs) begin
         bus_rdata = outs_rdata;
      end else begin
         bus_rdata = mem_rdata;
      end
   end

endmodule

`default_nettype wire

//--- source/data_memory.sv
`timescale 1ns/100ps
`default_nettype none

module data_memory #(
   parameter int addr_size = bus_defs_pkg::mem_addr_size
) (
   input  wire                      clk,
   input  wire                      cs,
   input  wire                      wen,
   input  wire [addr_size-1:0]      idx,
   input  wire bus_defs_pkg::word_t wdata,
   output bus_defs_pkg::word_t      rdata
);

   import bus_defs_pkg::*;

   word_t mem [0:(1 << addr_size)-1];

   always_ff @(posedge clk) begin
      if (cs && wen) begin
         mem[idx] <= wdata;
      end
   end

   // async read, the bus expects data in the address cycle
   assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- source/interval_timer.sv
`timescale 1ns/100ps
`default_nettype none

module interval_timer (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          io_clk,
   input  wire                          cs,
   input  wire                          wen,
   input  wire periph_defs_pkg::tmr_reg_t reg_sel,
   input  wire bus_defs_pkg::word_t     wdata,
   output bus_defs_pkg::word_t          rdata,
   output bus_defs_pkg::word_t          tmr,
   output bus_defs_pkg::word_t          ctr,
   output bus_defs_pkg::word_t          arr,
   output logic                         ar_reached,
   output logic                         irq
);

   import bus_defs_pkg::*;
   import periph_defs_pkg::*;

   // sync flops followed by the edge flop
   logic [sync_stages:0] io_sync;
   logic                 tick;
   logic                 ctrl_en;
   logic                 ctrl_irq_en;
   logic                 wr_ctrl;
   logic                 wr_arr;
   logic                 wr_ctr;
   logic                 wr_stat;
   logic                 wrap;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         io_sync <= '0;
      end else begin
         io_sync <= {io_sync[sync_stages-1:0], io_clk};
      end
   end

   // rising edge of the io clock
   assign tick = io_sync[sync_stages-1] & ~io_sync[sync_stages];

   assign wr_ctrl = cs & wen & (reg_sel == tmr_reg_ctrl);
   assign wr_arr  = cs & wen & (reg_sel == tmr_reg_arr);
   assign wr_ctr  = cs & wen & (reg_sel == tmr_reg_ctr);
   assign wr_stat = cs & wen & (reg_sel == tmr_reg_stat);

   // a bus load of ctr wins over counting
   assign wrap = tick & ctrl_en & (ctr == arr) & ~wr_ctr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tmr         <= '0;
         ctrl_en     <= 1'b0;
         ctrl_irq_en <= 1'b0;
         arr         <= '0;
      end else begin
         if (tick) begin
            tmr <= tmr + word_t'(1);
         end
         if (wr_ctrl) begin
            ctrl_en     <= wdata[ctrl_en_bit];
            ctrl_irq_en <= wdata[ctrl_irq_en_bit];
         end
         if (wr_arr) begin
            arr <= wdata;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctr        <= '0;
         ar_reached <= 1'b0;
      end else begin
         if (wr_ctr) begin
            ctr <= wdata;
         end else if (wrap) begin
            ctr <= '0;
         end else if (tick && ctrl_en) begin
            ctr <= ctr + word_t'(1);
         end
         // sticky, a wrap beats a clear
         if (wrap) begin
            ar_reached <= 1'b1;
         end else if (wr_stat) begin
            ar_reached <= 1'b0;
         end
      end
   end

   assign irq = ar_reached & ctrl_irq_en;

   always_comb begin
      rdata = '0;
      case (reg_sel)
         tmr_reg_ctrl: begin
            rdata[ctrl_en_bit]     = ctrl_en;
            rdata[ctrl_irq_en_bit] = ctrl_irq_en;
         end
         tmr_reg_arr:  rdata = arr;
         tmr_reg_ctr:  rdata = ctr;
         tmr_reg_stat: rdata[0] = ar_reached;
      endcase
   end

endmodule

`default_nettype wire

//--- source/gpio_in_port.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_in_port (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire bus_defs_pkg::word_t io_in,
   output bus_defs_pkg::word_t      rdata
);

   import bus_defs_pkg::*;
   import periph_defs_pkg::*;

   word_t sync_q [sync_stages];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < sync_stages; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= io_in;
         for (int i = 1; i < sync_stages; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign rdata = sync_q[sync_stages-1];

endmodule

`default_nettype wire

//--- source/gpio_out_bank.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_out_bank (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            cs,
   input  wire                            wen,
   input  wire periph_defs_pkg::port_sel_t port_sel,
   input  wire bus_defs_pkg::word_t       wdata,
   output bus_defs_pkg::word_t            rdata,
   output bus_defs_pkg::word_t            porta,
   output bus_defs_pkg::word_t            portb,
   output bus_defs_pkg::word_t            portc,
   output bus_defs_pkg::word_t            portd
);

   import bus_defs_pkg::*;
   import periph_defs_pkg::*;

   word_t port_q [port_count];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < port_count; i++) begin
            port_q[i] <= '0;
         end
      end else if (cs && wen) begin
         port_q[port_sel] <= wdata;
      end
   end

   // readback of the selected port
   assign rdata = port_q[port_sel];

   assign porta = port_q[0];
   assign portb = port_q[1];
   assign portc = port_q[2];
   assign portd = port_q[3];

endmodule

`default_nettype wire

//--- source/comp.sv
`timescale 1ns/100ps
`default_nettype none

module comp (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      clk10m,
   input  wire bus_defs_pkg::addr_t bus_addr,
   input  wire bus_defs_pkg::word_t bus_wdata,
   input  wire                      bus_wen,
   input  wire bus_defs_pkg::word_t porti,
   input  wire bus_defs_pkg::word_t portj,
   output bus_defs_pkg::word_t      bus_rdata,
   output bus_defs_pkg::word_t      porta,
   output bus_defs_pkg::word_t      portb,
   output bus_defs_pkg::word_t      portc,
   output bus_defs_pkg::word_t      portd,
   output bus_defs_pkg::word_t      tmr,
   output bus_defs_pkg::word_t      ctr,
   output bus_defs_pkg::word_t      arr,
   output logic                     ar_reached,
   output bus_defs_pkg::word_t      irqs
);

   import bus_defs_pkg::*;
   import periph_defs_pkg::*;

   logic      cs_mem;
   logic      cs_timer;
   logic      cs_outs;
   word_t     mem_rdata;
   word_t     timer_rdata;
   word_t     porti_rdata;
   word_t     portj_rdata;
   word_t     outs_rdata;
   logic      irq_timer;
   mem_idx_t  mem_idx;
   tmr_reg_t  timer_reg;
   port_sel_t out_sel;

   // slave offsets from the low address bits
   assign mem_idx   = bus_addr[mem_addr_size-1:0];
   assign timer_reg = bus_addr[$bits(tmr_reg_t)-1:0];
   assign out_sel   = bus_addr[$bits(port_sel_t)-1:0];

   addr_decode i_addr_decode (
      .bus_addr    (bus_addr),
      .mem_rdata   (mem_rdata),
      .timer_rdata (timer_rdata),
      .porti_rdata (porti_rdata),
      .portj_rdata (portj_rdata),
      .outs_rdata  (outs_rdata),
      .cs_mem      (cs_mem),
      .cs_timer    (cs_timer),
      .cs_porti    (),
      .cs_portj    (),
      .cs_outs     (cs_outs),
      .bus_rdata   (bus_rdata)
   );

   data_memory #(.addr_size(mem_addr_size)) i_data_memory (
      .clk   (clk),
      .cs    (cs_mem),
      .wen   (bus_wen),
      .idx   (mem_idx),
      .wdata (bus_wdata),
      .rdata (mem_rdata)
   );

   interval_timer i_timer (
      .clk        (clk),
      .rst_n      (rst_n),
      .io_clk     (clk10m),
      .cs         (cs_timer),
      .wen        (bus_wen),
      .reg_sel    (timer_reg),
      .wdata      (bus_wdata),
      .rdata      (timer_rdata),
      .tmr        (tmr),
      .ctr        (ctr),
      .arr        (arr),
      .ar_reached (ar_reached),
      .irq        (irq_timer)
   );

   gpio_in_port i_porti (
      .clk   (clk),
      .rst_n (rst_n),
      .io_in (porti),
      .rdata (porti_rdata)
   );

   gpio_in_port i_portj (
      .clk   (clk),
      .rst_n (rst_n),
      .io_in (portj),
      .rdata (portj_rdata)
   );

   gpio_out_bank i_out_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .cs       (cs_outs),
      .wen      (bus_wen),
      .port_sel (out_sel),
      .wdata    (bus_wdata),
      .rdata    (outs_rdata),
      .porta    (porta),
      .portb    (portb),
      .portc    (portc),
      .portd    (portd)
   );

   // timer owns irq 0 and the rest stay zero
   assign irqs = {{($bits(word_t)-1){1'b0}}, irq_timer};

endmodule

`default_nettype wire

//--- testbench/comp_chk.sv
`timescale 1ns/100ps
`default_nettype none

module comp_chk (
   input wire                      clk,
   input wire                      rst_n,
   input wire                      ctrl_en,
   input wire                      ctrl_irq_en,
   input wire bus_defs_pkg::addr_t bus_addr,
   input wire                      bus_wen,
   input wire bus_defs_pkg::word_t porta,
   input wire bus_defs_pkg::word_t portb,
   input wire bus_defs_pkg::word_t portc,
   input wire bus_defs_pkg::word_t portd,
   input wire bus_defs_pkg::word_t ctr,
   input wire bus_defs_pkg::word_t arr,
   input wire                      ar_reached,
   input wire bus_defs_pkg::word_t irqs
);

   import bus_defs_pkg::*;

   logic wr_outs;
   int   fail_count = 0;

   // a bus write that lands in the output bank
   assign wr_outs = bus_wen && (bus_addr[31:16] == '0) &&
                    (bus_addr[15:12] == region_portabcd);

   ctr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      ctrl_en |-> (ctr <= arr))
   else begin
      $error("ctr is above arr while the timer is enabled");
      fail_count++;
   end

   // timer interrupt in bit 0 and nothing above it
   irqs_from_timer: assert property (@(posedge clk) disable iff (!rst_n)
      irqs == {31'b0, ar_reached && ctrl_irq_en})
   else begin
      $error("irqs does not hold the timer interrupt alone in bit 0");
      fail_count++;
   end

   ports_need_write: assert property (@(posedge clk) disable iff (!rst_n)
      $changed({porta, portb, portc, portd}) |-> $past(wr_outs))
   else begin
      $error("an output port changed without a write to region 15");
      fail_count++;
   end

   // flag only rises on the wrap edge
   flag_on_wrap: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ar_reached) |-> (ctr == '0) && ($past(ctr) == $past(arr)))
   else begin
      $error("ar_reached rose without ctr wrapping from arr to zero");
      fail_count++;
   end

endmodule

bind comp comp_chk i_comp_chk (
   .clk         (clk),
   .rst_n       (rst_n),
   .ctrl_en     (i_timer.ctrl_en),
   .ctrl_irq_en (i_timer.ctrl_irq_en),
   .bus_addr    (bus_addr),
   .bus_wen     (bus_wen),
   .porta       (porta),
   .portb       (portb),
   .portc       (portc),
   .portd       (portd),
   .ctr         (ctr),
   .arr         (arr),
   .ar_reached  (ar_reached),
   .irqs        (irqs)
);

`default_nettype wire

//--- testbench/comp_tb.sv
`timescale 1ns/100ps
`default_nettype none

module comp_tb;

   import bus_defs_pkg::*;
   import periph_defs_pkg::*;

   localparam int wait_limit = 400;

   logic        clk;
   logic        rst_n;
   logic        clk10m;
   addr_t       bus_addr;
   word_t       bus_wdata;
   logic        bus_wen;
   word_t       porti;
   word_t       portj;
   word_t       bus_rdata;
   word_t       porta;
   word_t       portb;
   word_t       portc;
   word_t       portd;
   word_t       tmr;
   word_t       ctr;
   word_t       arr;
   logic        ar_reached;
   word_t       irqs;
   logic [31:0] lfsr_state = 32'hc929a45b;
   word_t       mem_model [mem_idx_t];
   word_t       port_model [port_count];
   mem_idx_t    written [$];
   int          mismatch_count = 0;
   int          timeout_count = 0;

   comp i_comp (
      .clk        (clk),
      .rst_n      (rst_n),
      .clk10m     (clk10m),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_wen    (bus_wen),
      .porti      (porti),
      .portj      (portj),
      .bus_rdata  (bus_rdata),
      .porta      (porta),
      .portb      (portb),
      .portc      (portc),
      .portd      (portd),
      .tmr        (tmr),
      .ctr        (ctr),
      .arr        (arr),
      .ar_reached (ar_reached),
      .irqs       (irqs)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // offset keeps io clock edges clear of clk edges
   initial begin
      clk10m = 1'b0;
      #20;
      forever #350 clk10m = ~clk10m;
   end

   // fibonacci lfsr with taps 32 22 2 1
   function automatic word_t next_random(input int n);
      word_t r;
      logic  fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic addr_t make_addr(input logic [15:0] upper, input logic [3:0] region,
                                       input logic [11:0] offset);
      return {upper, region, offset};
   endfunction

   task automatic write_word(input addr_t addr, input word_t data);
      @(posedge clk);
      bus_addr  <= addr;
      bus_wdata <= data;
      bus_wen   <= 1'b1;
      @(posedge clk);
      bus_wen   <= 1'b0;
   endtask

   // combinational read data sampled mid cycle
   task automatic read_word(input addr_t addr, output word_t data);
      @(posedge clk);
      bus_addr <= addr;
      bus_wen  <= 1'b0;
      @(negedge clk);
      data = bus_rdata;
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      assert (actual === expected) else begin
         $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
         mismatch_count++;
      end
   endtask

   task automatic read_check(input addr_t addr, input word_t expected, input string name);
      word_t rd;
      read_word(addr, rd);
      check_value(name, expected, rd);
   endtask

   task automatic check_ports();
      @(negedge clk);
      check_value("porta", port_model[0], porta);
      check_value("portb", port_model[1], portb);
      check_value("portc", port_model[2], portc);
      check_value("portd", port_model[3], portd);
      for (int p = 0; p < port_count; p++) begin
         read_check(make_addr(16'h0, region_portabcd, 12'(p)), port_model[p], "port readback");
      end
   endtask

   initial begin
      word_t       value;
      word_t       rnd;
      word_t       rd;
      word_t       ctr_held;
      word_t       tmr_start;
      mem_idx_t    idx;
      port_sel_t   sel;
      logic [15:0] upper;
      int          cycles;
      int          total;

      rst_n     = 1'b0;
      bus_addr  = '0;
      bus_wdata = '0;
      bus_wen   = 1'b0;
      porti     = '0;
      portj     = '0;
      for (int p = 0; p < port_count; p++) begin
         port_model[p] = '0;
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      @(negedge clk);
      check_value("porta", '0, porta);
      check_value("portb", '0, portb);
      check_value("portc", '0, portc);
      check_value("portd", '0, portd);
      check_value("tmr", '0, tmr);
      check_value("ctr", '0, ctr);
      check_value("arr", '0, arr);
      check_value("ar_reached", '0, {31'b0, ar_reached});
      check_value("irqs", '0, irqs);

      // memory through random aliases of regions 0 to 3
      for (int n = 0; n < 16; n++) begin
         rnd = next_random(mem_addr_size);
         idx = rnd[mem_addr_size-1:0];
         rnd = next_random(2);
         value = next_random(32);
         write_word(make_addr(16'h0, rnd[3:0], idx), value);
         mem_model[idx] = value;
         written.push_back(idx);
      end
      foreach (written[k]) begin
         idx = written[k];
         rnd = next_random(2);
         read_check(make_addr(16'h0, rnd[3:0], idx), mem_model[idx], "mem alias");
         rnd = next_random(3);
         read_check(make_addr(16'h0, rnd[3:0] + 4'd4, idx), mem_model[idx], "mem unmapped");
         rnd = next_random(16);
         upper = rnd[15:0] | 16'h0001;
         rnd = next_random(4);
         read_check(make_addr(upper, rnd[3:0], idx), mem_model[idx], "mem upper bits");
      end

      for (int n = 0; n < 8; n++) begin
         rnd = next_random(2);
         sel = rnd[1:0];
         value = next_random(32);
         write_word(make_addr(16'h0, region_portabcd, 12'(sel)), value);
         port_model[sel] = value;
         check_ports();
      end
      // above 64k nothing is selected
      rnd = next_random(16);
      upper = rnd[15:0] | 16'h0001;
      rnd = next_random(2);
      sel = rnd[1:0];
      value = next_random(32);
      write_word(make_addr(upper, region_portabcd, 12'(sel)), value);
      check_ports();

      for (int n = 0; n < 4; n++) begin
         value = next_random(32);
         rnd = next_random(32);
         @(posedge clk);
         porti <= value;
         portj <= rnd;
         repeat (sync_stages + 1) @(posedge clk);
         read_check(make_addr(16'h0, region_porti, 12'h0), value, "porti");
         read_check(make_addr(16'h0, region_portj, 12'h0), rnd, "portj");
      end

      // short reload and count with interrupt
      write_word(make_addr(16'h0, region_timer, 12'(tmr_reg_arr)), 32'd3);
      value = '0;
      value[ctrl_en_bit] = 1'b1;
      value[ctrl_irq_en_bit] = 1'b1;
      write_word(make_addr(16'h0, region_timer, 12'(tmr_reg_ctrl)), value);
      read_check(make_addr(16'h0, region_timer, 12'(tmr_reg_arr)), 32'd3, "arr register");
      check_value("arr", 32'd3, arr);
      read_check(make_addr(16'h0, region_timer, 12'(tmr_reg_ctrl)), value, "ctrl register");
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!ar_reached && cycles < wait_limit);
      if (!ar_reached) begin
         $display("Timeout: ar_reached was never set after enabling the timer");
         timeout_count++;
      end
      read_word(make_addr(16'h0, region_timer, 12'(tmr_reg_ctr)), rd);
      assert (rd <= 32'd3) else begin
         $display("Mismatch at %0t: ctr expected at most %h, got %h", $time, 32'd3, rd);
         mismatch_count++;
      end
      read_check(make_addr(16'h0, region_timer, 12'(tmr_reg_stat)), 32'd1, "stat");
      check_value("irqs", 32'd1, irqs);

      write_word(make_addr(16'h0, region_timer, 12'(tmr_reg_ctrl)), '0);
      write_word(make_addr(16'h0, region_timer, 12'(tmr_reg_stat)), 32'd1);
      read_check(make_addr(16'h0, region_timer, 12'(tmr_reg_stat)), '0, "stat");
      check_value("irqs", '0, irqs);
      read_word(make_addr(16'h0, region_timer, 12'(tmr_reg_ctr)), ctr_held);
      tmr_start = tmr;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (tmr < tmr_start + 3 && cycles < wait_limit);
      if (tmr < tmr_start + 3) begin
         $display("Timeout: tmr stopped counting ticks while the timer was disabled");
         timeout_count++;
      end
      read_check(make_addr(16'h0, region_timer, 12'(tmr_reg_ctr)), ctr_held, "ctr");

      total = mismatch_count + timeout_count + i_comp.i_comp_chk.fail_count;
      $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               mismatch_count, timeout_count, i_comp.i_comp_chk.fail_count);
      if (total == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- comp.f
source/bus_defs_pkg.sv
source/periph_defs_pkg.sv
source/addr_decode.sv
source/data_memory.sv
source/interval_timer.sv
source/gpio_in_port.sv
source/gpio_out_bank.sv
source/comp.sv
testbench/comp_chk.sv
testbench/comp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the comp testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module comp_tb \
   -f comp.f \
   -Mdir obj_dir \
   -o comp_sim

# let every assertion failure be counted instead of stopping at the first
./obj_dir/comp_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
